/* Makefile */
# Verilator flow for the output feature-map store

TOP := out_fm_store_tb

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o sim
	./obj_dir/sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module out_fm_store

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* build.f */
+incdir+logic
logic/fm_pkg.sv
logic/nest3_counter.sv
logic/sync_fifo.sv
logic/fifo_to_ram.sv
logic/out_fm_ram.sv
logic/out_fm_store.sv
test/out_fm_store_tb.sv

/* logic/fifo_to_ram.sv */
`default_nettype none

`include "fm_config.svh"

module fifo_to_ram (
    input  logic             clk,
    input  logic             rst,
    // Transfer control
    input  logic             start,
    output logic             busy,
    output logic             done,
    // FIFO side
    output logic             fifo_pop,
    input  logic             fifo_empty,
    input  fm_pkg::fm_word_t data_from_fifo,
    // RAM write side
    output logic             ram_wena,
    output fm_pkg::fm_addr_t ram_addr,
    output fm_pkg::fm_word_t data_to_ram,
    // Tile origin in the full map
    input  fm_pkg::fm_addr_t tile_base_n,
    input  fm_pkg::fm_addr_t tile_base_row,
    input  fm_pkg::fm_addr_t tile_base_col
);
    import fm_pkg::*;

    // Words per channel plane
    localparam int MAP_RC = `FM_R * `FM_C;

    mover_state_t state;

    // Bases held for the whole tile
    fm_addr_t     base_n;
    fm_addr_t     base_row;
    fm_addr_t     base_col;

    // Tile-local coordinates
    fm_addr_t     tc;
    fm_addr_t     tr;
    fm_addr_t     tn;
    logic         cnt_last;

    // Map coordinates of the current word
    fm_addr_t     pos_n;
    fm_addr_t     pos_row;
    fm_addr_t     pos_col;
    logic         legal;
    fm_addr_t     addr_calc;

    assign busy = (state != MOVER_IDLE);

    // Pop whenever a word is waiting during the move
    assign fifo_pop = (state == MOVER_MOVE) && !fifo_empty;

    // Column fastest, channel slowest
    nest3_counter #(
        .N0_MAX (`FM_TC),
        .N1_MAX (`FM_TR),
        .N2_MAX (`FM_TN)
    ) u_cnt (
        .clk  (clk),
        .rst  (rst),
        .ena  (fifo_pop),
        .cnt0 (tc),
        .cnt1 (tr),
        .cnt2 (tn),
        .last (cnt_last)
    );

    assign pos_n   = base_n + tn;
    assign pos_row = base_row + tr;
    assign pos_col = base_col + tc;

    // Edge tiles hang past the map, those words are dropped
    assign legal = (pos_n < fm_addr_t'(`FM_N)) && (pos_row < fm_addr_t'(`FM_R)) &&
                   (pos_col < fm_addr_t'(`FM_C));

    // Linear address, only meaningful when legal
    assign addr_calc = fm_addr_t'(pos_n * MAP_RC + pos_row * `FM_C + pos_col);

    // FSM and done pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MOVER_IDLE;
            done  <= 1'b0;
        end else begin
            done <= (state == MOVER_DRAIN);
            unique case (state)
                MOVER_IDLE:  if (start) state <= MOVER_MOVE;
                MOVER_MOVE:  if (fifo_pop && cnt_last) state <= MOVER_DRAIN;
                MOVER_DRAIN: state <= MOVER_IDLE;
                default:     state <= MOVER_IDLE;
            endcase
        end
    end

    // Latch bases on an accepted start
    always_ff @(posedge clk) begin
        if (state == MOVER_IDLE && start) begin
            base_n   <= tile_base_n;
            base_row <= tile_base_row;
            base_col <= tile_base_col;
        end
    end

    // Write strobe lines up with FIFO read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_wena <= 1'b0;
        end else begin
            ram_wena <= fifo_pop && legal;
        end
    end

    // Address registered alongside the pop
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            ram_addr <= addr_calc;
        end
    end

    // FIFO word arrives in the write cycle
    assign data_to_ram = data_from_fifo;

    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |-> !fifo_empty);

    // Done only on the DRAIN to IDLE step
    a_done_step: assert property (@(posedge clk) disable iff (rst)
        done |-> ($past(state) == MOVER_DRAIN) && (state == MOVER_IDLE));

    // Counters rest at zero between tiles, so every tile starts at word 0
    a_idle_cnt_zero: assert property (@(posedge clk) disable iff (rst)
        (state == MOVER_IDLE) |-> (tc == '0) && (tr == '0) && (tn == '0));

endmodule

`default_nettype wire

/* logic/fm_config.svh */
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// Full output feature map
// Channel count
`define FM_N 4
// Rows per channel
`define FM_R 12
// Columns per row
`define FM_C 10

// Tile produced by one compute pass
// Channels per tile
`define FM_TN 2
// Rows per tile
`define FM_TR 4
// Columns per tile
`define FM_TC 4

// Data word width
`define FM_DW 16

// RAM address width, enough for N*R*C = 480 words
`define FM_AW 9

// Output FIFO holds exactly one tile
`define FM_FIFO_DEPTH 32

`endif

/* logic/fm_pkg.sv */
`default_nettype none

`include "fm_config.svh"

package fm_pkg;

    // One feature-map word
    typedef logic [`FM_DW-1:0] fm_word_t;

    // RAM address, also used for tile coordinates and counters
    typedef logic [`FM_AW-1:0] fm_addr_t;

    // Mover FSM
    typedef enum logic [1:0] {
        // Waiting for start
        MOVER_IDLE,
        // Popping FIFO and walking the tile
        MOVER_MOVE,
        // Last write in flight
        MOVER_DRAIN
    } mover_state_t;

endpackage

`default_nettype wire

/* logic/nest3_counter.sv */
`default_nettype none

module nest3_counter #(
    // Wrap points, each counter runs 0 .. MAX-1
    parameter int N0_MAX = 4,
    parameter int N1_MAX = 4,
    parameter int N2_MAX = 2
) (
    input  logic             clk,
    input  logic             rst,
    // Advance by one step
    input  logic             ena,
    // Fastest counter
    output fm_pkg::fm_addr_t cnt0,
    output fm_pkg::fm_addr_t cnt1,
    // Slowest counter
    output fm_pkg::fm_addr_t cnt2,
    // All counters at their top value
    output logic             last
);
    import fm_pkg::*;

    logic wrap0;
    logic wrap1;
    logic wrap2;

    // Top-value detect per level
    assign wrap0 = (cnt0 == fm_addr_t'(N0_MAX - 1));
    assign wrap1 = (cnt1 == fm_addr_t'(N1_MAX - 1));
    assign wrap2 = (cnt2 == fm_addr_t'(N2_MAX - 1));

    // Enabling step with last high is the final one
    assign last = wrap0 && wrap1 && wrap2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (ena) begin
            if (wrap0) begin
                cnt0 <= '0;
                // Carry into the middle level
                if (wrap1) begin
                    cnt1 <= '0;
                    // Outer level wraps too, so all return to zero
                    cnt2 <= wrap2 ? '0 : cnt2 + 1'b1;
                end else begin
                    cnt1 <= cnt1 + 1'b1;
                end
            end else begin
                cnt0 <= cnt0 + 1'b1;
            end
        end
    end

    // Every count stays inside its range
    a_cnt_bound: assert property (@(posedge clk) disable iff (rst)
        (cnt0 < fm_addr_t'(N0_MAX)) && (cnt1 < fm_addr_t'(N1_MAX)) &&
        (cnt2 < fm_addr_t'(N2_MAX)));

endmodule

`default_nettype wire

/* logic/out_fm_ram.sv */
`default_nettype none

`include "fm_config.svh"

module out_fm_ram (
    input  logic             clk,
    // Write port from the mover
    input  logic             wena,
    input  fm_pkg::fm_addr_t waddr,
    input  fm_pkg::fm_word_t wdata,
    // Read port for result readout
    input  fm_pkg::fm_addr_t rd_addr,
    output fm_pkg::fm_word_t rd_data
);
    import fm_pkg::*;

    // One word per map position
    localparam int WORDS = `FM_N * `FM_R * `FM_C;

    fm_word_t mem [WORDS];

    // Write lands at the edge
    always_ff @(posedge clk) begin
        if (wena) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, one cycle after rd_addr
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Mover never writes outside the map
    a_waddr_range: assert property (@(posedge clk)
        wena |-> (waddr < fm_addr_t'(WORDS)));

endmodule

`default_nettype wire

/* logic/out_fm_store.sv */
`default_nettype none

`include "fm_config.svh"

module out_fm_store (
    input  logic             clk,
    input  logic             rst,
    // Words from the compute array
    input  logic             push,
    input  fm_pkg::fm_word_t push_data,
    output logic             fifo_full,
    // Transfer control
    input  logic             start,
    input  fm_pkg::fm_addr_t tile_base_n,
    input  fm_pkg::fm_addr_t tile_base_row,
    input  fm_pkg::fm_addr_t tile_base_col,
    output logic             busy,
    output logic             done,
    // Result readout
    input  fm_pkg::fm_addr_t rd_addr,
    output fm_pkg::fm_word_t rd_data
);
    import fm_pkg::*;

    // FIFO to mover
    logic     fifo_pop;
    logic     fifo_empty;
    fm_word_t fifo_rd_data;

    // Mover to RAM
    logic     ram_wena;
    fm_addr_t ram_addr;
    fm_word_t ram_wdata;

    // Tile buffer
    sync_fifo #(
        .DEPTH (`FM_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (fifo_pop),
        .rd_data   (fifo_rd_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    // Tile placement into the map
    fifo_to_ram u_mover (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .busy           (busy),
        .done           (done),
        .fifo_pop       (fifo_pop),
        .fifo_empty     (fifo_empty),
        .data_from_fifo (fifo_rd_data),
        .ram_wena       (ram_wena),
        .ram_addr       (ram_addr),
        .data_to_ram    (ram_wdata),
        .tile_base_n    (tile_base_n),
        .tile_base_row  (tile_base_row),
        .tile_base_col  (tile_base_col)
    );

    // Full output map
    out_fm_ram u_ram (
        .clk     (clk),
        .wena    (ram_wena),
        .waddr   (ram_addr),
        .wdata   (ram_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
`default_nettype none

`include "fm_config.svh"

module sync_fifo #(
    parameter int DEPTH = `FM_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    // Write side
    input  logic             push,
    input  fm_pkg::fm_word_t push_data,
    // Read side, data shows one cycle after pop
    input  logic             pop,
    output fm_pkg::fm_word_t rd_data,
    // Fill levels
    output logic             full,
    output logic             empty
);
    import fm_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Storage
    fm_word_t       mem [DEPTH];

    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    // Occupancy, one bit wider than the pointers
    logic [PW:0]    count;

    logic           do_push;
    logic           do_pop;

    assign full  = (count == (PW+1)'(DEPTH));
    assign empty = (count == '0);

    // Push while full is dropped
    assign do_push = push && !full;
    // Pop while empty is ignored
    assign do_pop  = pop && !empty;

    // Pointer and count control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            unique case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Buffer write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Registered read data
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Occupancy never above DEPTH
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count <= (PW+1)'(DEPTH));

    // Full and not popped stays full
    a_full_hold: assert property (@(posedge clk) disable iff (rst)
        full && !do_pop |=> full);

    // Empty and not pushed stays empty, so count cannot wrap below zero
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        empty && !do_push |=> empty);

endmodule

`default_nettype wire

/* test/out_fm_store_tb.sv */
`default_nettype none

`include "fm_config.svh"

module out_fm_store_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fm_pkg::*;

    localparam int TILE_WORDS   = `FM_TN * `FM_TR * `FM_TC;
    localparam int MAP_WORDS    = `FM_N * `FM_R * `FM_C;
    localparam int RANDOM_TILES = 16;
    // 20 tiles, each with worst push gaps plus a full readback
    localparam int CYCLE_LIMIT  = 20 * (TILE_WORDS * 4 + 500);

    logic     clk;
    logic     rst;
    logic     push;
    fm_word_t push_data;
    logic     fifo_full;
    logic     start;
    fm_addr_t tile_base_n;
    fm_addr_t tile_base_row;
    fm_addr_t tile_base_col;
    logic     busy;
    logic     done;
    fm_addr_t rd_addr;
    fm_word_t rd_data;

    integer   seed;
    int       cycle_count;
    // Words of the tile under test, in push order
    fm_word_t tile_words [TILE_WORDS];
    // Reference map and which positions hold a known value
    fm_word_t model_mem [MAP_WORDS];
    logic     model_written [MAP_WORDS];

    out_fm_store uut (
        .clk           (clk),
        .rst           (rst),
        .push          (push),
        .push_data     (push_data),
        .fifo_full     (fifo_full),
        .start         (start),
        .tile_base_n   (tile_base_n),
        .tile_base_row (tile_base_row),
        .tile_base_col (tile_base_col),
        .busy          (busy),
        .done          (done),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > CYCLE_LIMIT) begin
                $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("TEST FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic make_tile_words();
        for (int i = 0; i < TILE_WORDS; i++) begin
            tile_words[i] = fm_word_t'($random(seed));
        end
    endtask

    // Reference placement, tc fastest and tn slowest, clipped at the map edge
    task automatic model_tile(input int bn, input int br, input int bc);
        int idx;
        int n;
        int r;
        int c;
        idx = 0;
        for (int tn = 0; tn < `FM_TN; tn++) begin
            for (int tr = 0; tr < `FM_TR; tr++) begin
                for (int tc = 0; tc < `FM_TC; tc++) begin
                    n = bn + tn;
                    r = br + tr;
                    c = bc + tc;
                    if (n < `FM_N && r < `FM_R && c < `FM_C) begin
                        model_mem[n * `FM_R * `FM_C + r * `FM_C + c] = tile_words[idx];
                        model_written[n * `FM_R * `FM_C + r * `FM_C + c] = 1'b1;
                    end
                    idx++;
                end
            end
        end
    endtask

    // One push per word, 0..max_gap idle cycles between words
    task automatic push_tile(input int max_gap, input logic mover_running);
        int gap;
        for (int i = 0; i < TILE_WORDS; i++) begin
            push      = 1'b1;
            push_data = tile_words[i];
            next_cycle();
            push = 1'b0;
            gap  = (max_gap > 0 && i < TILE_WORDS - 1) ?
                   int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) begin
                next_cycle();
                if (mover_running) begin
                    check_value("busy_during_push", 1, busy);
                    check_value("done_during_push", 0, done);
                end
            end
        end
    endtask

    task automatic start_tile(input int bn, input int br, input int bc);
        tile_base_n   = fm_addr_t'(bn);
        tile_base_row = fm_addr_t'(br);
        tile_base_col = fm_addr_t'(bc);
        start         = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    // Cycles counted from the edge that samples start
    task automatic wait_done(output int cycles);
        cycles = 1;
        while (!done) begin
            check_value("busy_until_done", 1, busy);
            next_cycle();
            cycles++;
        end
        next_cycle();
        // Pulse lasts one cycle only
        check_value("done_one_cycle", 0, done);
    endtask

    // Full-map read, data valid one cycle after the address
    task automatic readback_map(input string name);
        for (int a = 0; a < MAP_WORDS; a++) begin
            rd_addr = fm_addr_t'(a);
            next_cycle();
            check_value({name, "_extra_done"}, 0, done);
            if (model_written[a]) begin
                check_value($sformatf("%s addr %0d", name, a), model_mem[a], rd_data);
            end
        end
    endtask

    task automatic run_prefilled(input string name, input int bn, input int br,
                                 input int bc);
        int cycles;
        make_tile_words();
        push_tile(0, 1'b0);
        start_tile(bn, br, bc);
        wait_done(cycles);
        // Full FIFO at start gives one pop per cycle plus drain and done
        check_value({name, "_latency"}, TILE_WORDS + 2, cycles);
        model_tile(bn, br, bc);
        readback_map(name);
    endtask

    task automatic run_streamed(input string name, input int bn, input int br,
                                input int bc);
        int cycles;
        make_tile_words();
        start_tile(bn, br, bc);
        push_tile(3, 1'b1);
        wait_done(cycles);
        model_tile(bn, br, bc);
        readback_map(name);
    endtask

    task automatic run_overflow(input string name, input int bn, input int br,
                                input int bc);
        int cycles;
        make_tile_words();
        push_tile(0, 1'b0);
        check_value({name, "_full"}, 1, fifo_full);
        // Extra words must be dropped
        for (int i = 0; i < 5; i++) begin
            push      = 1'b1;
            push_data = fm_word_t'($random(seed));
            next_cycle();
            check_value({name, "_full_hold"}, 1, fifo_full);
        end
        push = 1'b0;
        start_tile(bn, br, bc);
        wait_done(cycles);
        check_value({name, "_full_clear"}, 0, fifo_full);
        model_tile(bn, br, bc);
        readback_map(name);
    endtask

    initial begin
        int bn;
        int br;
        int bc;
        seed          = 32'h86a33b42;
        rst           = 1'b1;
        push          = 1'b0;
        push_data     = '0;
        start         = 1'b0;
        tile_base_n   = '0;
        tile_base_row = '0;
        tile_base_col = '0;
        rd_addr       = '0;
        for (int a = 0; a < MAP_WORDS; a++) begin
            model_written[a] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();

        run_prefilled("interior", 0, 0, 0);
        // Clipped columns 10 and 11 would alias onto the next row's columns 0 and 1
        run_prefilled("col_edge", 0, 0, 8);
        run_streamed("stalled", 1, 4, 3);
        run_overflow("overflow", 2, 6, 5);

        // Any base inside the map, channel and row edges included
        for (int t = 0; t < RANDOM_TILES; t++) begin
            bn = int'($unsigned($random(seed)) % `FM_N);
            br = int'($unsigned($random(seed)) % `FM_R);
            bc = int'($unsigned($random(seed)) % `FM_C);
            // First tile sits on the last channel and the bottom rows
            if (t == 0) begin
                bn = `FM_N - 1;
                br = `FM_R - 2;
            end
            if (t % 2 == 0) begin
                run_prefilled($sformatf("random_%0d", t), bn, br, bc);
            end else begin
                run_streamed($sformatf("random_%0d", t), bn, br, bc);
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
